//--- logic/corelet_pkg.sv
`default_nettype none

package corelet_pkg;

    localparam int lanes        = 8;
    localparam int lane_bw      = 4;
    localparam int psum_bw      = 16;
    localparam int cols         = 8;
    localparam int positions    = 16;
    localparam int kij_count    = 9;
    localparam int act_base     = 72;   // activations sit above the 72 weight words
    localparam int i_addr_bw    = 7;
    localparam int o_addr_bw    = 4;
    localparam int flush_cycles = 2;

    typedef enum logic [2:0] {
        idle,
        load_weight,
        stream_act,
        flush,
        write_out
    } seq_state_e;

    typedef logic signed [lane_bw-1:0] w_lane_t;
    typedef logic [lane_bw-1:0] a_lane_t;

    // input sram word, decoded by whichever phase fetched it
    typedef union packed {
        w_lane_t [lanes-1:0] weight;
        a_lane_t [lanes-1:0] act;
    } sram_word_u;

    // marks the word that shows up on i_q next cycle
    typedef struct packed {
        logic                 valid;
        logic                 is_weight;
        logic [o_addr_bw-1:0] index;   // column for weights, position for acts
    } fetch_tag_t;

    typedef logic signed [psum_bw-1:0] psum_t;

    // column 0 in the low bits
    typedef psum_t [cols-1:0] psum_row_t;

    typedef struct packed {
        logic                 valid;
        logic [o_addr_bw-1:0] pos;
        psum_row_t            sums;
    } psum_beat_t;

    typedef struct packed {
        logic                 write;
        logic [o_addr_bw-1:0] addr;
    } out_req_t;

endpackage

`default_nettype wire

//--- logic/conv_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_sequencer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    output logic [corelet_pkg::i_addr_bw-1:0] i_addr,
    output logic                              i_cen,
    output logic                              i_wen,
    output corelet_pkg::fetch_tag_t           tag,
    output logic                              clear,
    output corelet_pkg::out_req_t             out_req,
    output logic                              op_done
);

    corelet_pkg::seq_state_e                state;
    corelet_pkg::seq_state_e                state_next;
    logic [3:0]                             kij;
    logic [3:0]                             kij_next;
    logic [corelet_pkg::o_addr_bw-1:0]      cnt;
    logic [corelet_pkg::o_addr_bw-1:0]      cnt_next;
    logic [corelet_pkg::i_addr_bw-1:0]      act_off;
    logic                                   fetch;
    logic                                   last_write;

    assign fetch = (state == corelet_pkg::load_weight) || (state == corelet_pkg::stream_act);
    assign last_write = (state == corelet_pkg::write_out) &&
                        (int'(cnt) == corelet_pkg::positions - 1);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= corelet_pkg::idle;
            kij     <= '0;
            cnt     <= '0;
            tag     <= '0;
            op_done <= 1'b0;
        end
        else
        begin
            state         <= state_next;
            kij           <= kij_next;
            cnt           <= cnt_next;
            tag.valid     <= fetch;     // word lands on i_q next cycle
            tag.is_weight <= (state == corelet_pkg::load_weight);
            tag.index     <= cnt;
            op_done       <= last_write;
        end
    end

    always_comb
    begin
        state_next = state;
        kij_next   = kij;
        cnt_next   = cnt + 4'd1;
        case (state)
            corelet_pkg::idle:
            begin
                cnt_next = '0;
                if (start)
                begin
                    state_next = corelet_pkg::load_weight;
                    kij_next   = '0;
                end
            end
            corelet_pkg::load_weight:
                if (int'(cnt) == corelet_pkg::cols - 1)
                begin
                    state_next = corelet_pkg::stream_act;
                    cnt_next   = '0;
                end
            corelet_pkg::stream_act:
                if (int'(cnt) == corelet_pkg::positions - 1)
                begin
                    cnt_next = '0;
                    if (int'(kij) == corelet_pkg::kij_count - 1)
                        state_next = corelet_pkg::flush;
                    else
                    begin
                        state_next = corelet_pkg::load_weight;
                        kij_next   = kij + 4'd1;
                    end
                end
            corelet_pkg::flush:     // lets the last beat reach the bank
                if (int'(cnt) == corelet_pkg::flush_cycles - 1)
                begin
                    state_next = corelet_pkg::write_out;
                    cnt_next   = '0;
                end
            corelet_pkg::write_out:
                if (last_write)
                begin
                    state_next = corelet_pkg::idle;
                    cnt_next   = '0;
                end
            default:
                state_next = corelet_pkg::idle;
        endcase
    end

    // top-left corner of the 3x3 window in the 6-wide activation map
    always_comb
    begin
        case (kij)
            4'd0:    act_off = 7'd0;
            4'd1:    act_off = 7'd1;
            4'd2:    act_off = 7'd2;
            4'd3:    act_off = 7'd6;
            4'd4:    act_off = 7'd7;
            4'd5:    act_off = 7'd8;
            4'd6:    act_off = 7'd12;
            4'd7:    act_off = 7'd13;
            default: act_off = 7'd14;
        endcase
        if (state == corelet_pkg::stream_act)
            i_addr = 7'(corelet_pkg::act_base) + act_off + {3'b000, cnt} +
                     {2'b00, cnt[3:2], 1'b0};   // skip two per row of four
        else
            i_addr = {kij, cnt[2:0]};   // kij*8 + column
    end

    assign i_cen   = !fetch;
    assign i_wen   = 1'b1;      // input sram is read only
    assign clear   = start && (state == corelet_pkg::idle);
    assign out_req = '{write: (state == corelet_pkg::write_out), addr: cnt};

endmodule

`default_nettype wire

//--- logic/mac_array.sv
`timescale 1ns/1ps
`default_nettype none

module mac_array (
    input  logic                    clk,
    input  logic                    reset,
    input  corelet_pkg::sram_word_u i_q,
    input  corelet_pkg::fetch_tag_t tag,
    output corelet_pkg::psum_beat_t beat
);

    corelet_pkg::sram_word_u           w_store [corelet_pkg::cols];
    corelet_pkg::psum_row_t            dot;
    corelet_pkg::psum_row_t            sums_q;
    logic [corelet_pkg::o_addr_bw-1:0] pos_q;
    logic                              valid_q;
    logic                              act_in;

    assign act_in = tag.valid && !tag.is_weight;

    // one weight word per column
    always_ff @(posedge clk)
    begin
        if (tag.valid && tag.is_weight)
            w_store[tag.index[2:0]] <= i_q;
    end

    // column dot products, unsigned acts times signed weights
    always_comb
    begin
        for (int c = 0; c < corelet_pkg::cols; c++)
        begin
            dot[c] = '0;
            for (int l = 0; l < corelet_pkg::lanes; l++)
                dot[c] = dot[c] +
                         corelet_pkg::psum_t'($signed({1'b0, i_q.act[l]})) *
                         corelet_pkg::psum_t'($signed(w_store[c].weight[l]));
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            valid_q <= 1'b0;
        else
            valid_q <= act_in;
    end

    always_ff @(posedge clk)
    begin
        if (act_in)
        begin
            sums_q <= dot;
            pos_q  <= tag.index;
        end
    end

    assign beat = '{valid: valid_q, pos: pos_q, sums: sums_q};

endmodule

`default_nettype wire

//--- logic/psum_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module psum_accumulator (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              clear,
    input  corelet_pkg::psum_beat_t           beat,
    input  corelet_pkg::out_req_t             out_req,
    output corelet_pkg::psum_row_t            o_d,
    output logic [corelet_pkg::o_addr_bw-1:0] o_addr,
    output logic                              o_cen,
    output logic                              o_wen
);

    corelet_pkg::psum_row_t bank [corelet_pkg::positions];
    corelet_pkg::psum_row_t sum_row;

    always_comb
    begin
        for (int c = 0; c < corelet_pkg::cols; c++)
            sum_row[c] = bank[beat.pos][c] + beat.sums[c];  // wraps mod 2^16
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int p = 0; p < corelet_pkg::positions; p++)
                bank[p] <= '0;
        end
        else if (clear)     // fresh run
        begin
            for (int p = 0; p < corelet_pkg::positions; p++)
                bank[p] <= '0;
        end
        else if (beat.valid)
            bank[beat.pos] <= sum_row;
    end

    // write port follows the request in the same cycle
    assign o_d    = bank[out_req.addr];
    assign o_addr = out_req.addr;
    assign o_cen  = !out_req.write;
    assign o_wen  = !out_req.write;

endmodule

`default_nettype wire

//--- logic/corelet_top.sv
`timescale 1ns/1ps
`default_nettype none

module corelet_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              start,
    input  corelet_pkg::sram_word_u           i_q,
    output logic [corelet_pkg::i_addr_bw-1:0] i_addr,
    output logic                              i_cen,
    output logic                              i_wen,
    output corelet_pkg::psum_row_t            o_d,
    output logic [corelet_pkg::o_addr_bw-1:0] o_addr,
    output logic                              o_cen,
    output logic                              o_wen,
    output logic                              op_done
);

    corelet_pkg::fetch_tag_t tag;
    corelet_pkg::psum_beat_t beat;
    corelet_pkg::out_req_t   out_req;
    logic                    clear;

    conv_sequencer i_seq (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .i_addr  (i_addr),
        .i_cen   (i_cen),
        .i_wen   (i_wen),
        .tag     (tag),
        .clear   (clear),
        .out_req (out_req),
        .op_done (op_done)
    );

    mac_array i_mac (.clk(clk), .reset(reset), .i_q(i_q), .tag(tag), .beat(beat));

    psum_accumulator i_acc (
        .clk     (clk),
        .reset   (reset),
        .clear   (clear),
        .beat    (beat),
        .out_req (out_req),
        .o_d     (o_d),
        .o_addr  (o_addr),
        .o_cen   (o_cen),
        .o_wen   (o_wen)
    );

endmodule

`default_nettype wire

//--- bench/corelet_props.sv
`timescale 1ns/1ps
`default_nettype none

module corelet_props (
    input logic                              clk,
    input logic                              reset,
    input logic                              start,
    input logic                              i_cen,
    input logic                              i_wen,
    input logic [corelet_pkg::o_addr_bw-1:0] o_addr,
    input logic                              o_cen,
    input logic                              o_wen,
    input logic                              op_done
);

    // input sram is read only
    assert property (@(posedge clk) i_wen)
        else $error("i_wen went low");

    assert property (@(posedge clk) o_wen == o_cen)
        else $error("o_wen and o_cen disagree");

    assert property (@(posedge clk) disable iff (reset) op_done |=> !op_done)
        else $error("op_done held longer than one cycle");

    // reads only open right after an accepted start
    assert property (@(posedge clk) disable iff (reset) $fell(i_cen) |-> $past(start))
        else $error("input reads began without a start");

    assert property (@(posedge clk) disable iff (reset) !o_cen |-> i_cen)
        else $error("input read during write-out");

    assert property (@(posedge clk) disable iff (reset) op_done |-> (i_cen && o_cen))
        else $error("sram still enabled at op_done");

    // burst of 16 writes, no gaps
    assert property (@(posedge clk) disable iff (reset) $fell(o_cen) |-> (o_addr == '0))
        else $error("write burst did not start at address 0");

    assert property (@(posedge clk) disable iff (reset)
        (!o_cen && o_addr != 4'd15) |=> (!o_cen && o_addr == $past(o_addr) + 4'd1))
        else $error("write burst broken or out of order");

    assert property (@(posedge clk) disable iff (reset)
        (!o_cen && o_addr == 4'd15) |=> (o_cen && op_done))
        else $error("op_done did not follow the last write");

endmodule

bind corelet_top corelet_props i_props (
    .clk     (clk),
    .reset   (reset),
    .start   (start),
    .i_cen   (i_cen),
    .i_wen   (i_wen),
    .o_addr  (o_addr),
    .o_cen   (o_cen),
    .o_wen   (o_wen),
    .op_done (op_done)
);

`default_nettype wire

//--- bench/corelet_tb.sv
`timescale 1ns/1ps
`default_nettype none

module corelet_tb;

    logic                              clk = 1'b0;
    logic                              reset;
    logic                              start;
    corelet_pkg::sram_word_u           i_q = '0;
    logic [corelet_pkg::i_addr_bw-1:0] i_addr;
    logic                              i_cen;
    logic                              i_wen;
    corelet_pkg::psum_row_t            o_d;
    logic [corelet_pkg::o_addr_bw-1:0] o_addr;
    logic                              o_cen;
    logic                              o_wen;
    logic                              op_done;

    corelet_pkg::sram_word_u mem [128];
    corelet_pkg::psum_row_t  out_mem [corelet_pkg::positions];
    corelet_pkg::psum_row_t  exp_row [corelet_pkg::positions];
    int                      window_offset [9] = '{0, 1, 2, 6, 7, 8, 12, 13, 14};
    logic [15:0]             lfsr = 16'd27;
    int                      write_count = 0;
    int                      write_errors = 0;
    int                      run_errors = 0;
    int                      timeouts = 0;

    corelet_top i_dut (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .i_q     (i_q),
        .i_addr  (i_addr),
        .i_cen   (i_cen),
        .i_wen   (i_wen),
        .o_d     (o_d),
        .o_addr  (o_addr),
        .o_cen   (o_cen),
        .o_wen   (o_wen),
        .op_done (op_done)
    );

    always #2 clk = ~clk;

    // input sram, one cycle read latency
    always @(posedge clk)
    begin
        if (!i_cen)
            i_q <= mem[i_addr];
    end

    // output sram, every write checked against the model
    always @(posedge clk)
    begin
        if (!o_cen && !o_wen)
        begin
            assert (o_addr == 4'(write_count)) else
            begin
                write_errors++;
                $display("FAIL o_addr: got %h expected %h", o_addr, 4'(write_count));
            end
            assert (o_d == exp_row[o_addr]) else
            begin
                write_errors++;
                $display("FAIL o_d[%0d]: got %h expected %h", o_addr, o_d, exp_row[o_addr]);
            end
            out_mem[o_addr] <= o_d;
            write_count++;
        end
    end

    function automatic logic [15:0] step_lfsr(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hb400;
        else
            return s >> 1;
    endfunction

    task automatic fill_input_sram;
        logic [31:0] word;
        for (int a = 0; a < 128; a++)
        begin
            for (int b = 0; b < 32; b++)
            begin
                lfsr = step_lfsr(lfsr);
                word[b] = lfsr[0];  // one step per bit
            end
            mem[a] = word;
        end
    endtask

    // sum over kij and lanes of act times weight, mod 2^16
    task automatic build_model;
        corelet_pkg::sram_word_u           aw;
        corelet_pkg::sram_word_u           ww;
        logic [corelet_pkg::i_addr_bw-1:0] a_addr;
        logic [corelet_pkg::i_addr_bw-1:0] w_addr;
        int                                sum;
        for (int p = 0; p < corelet_pkg::positions; p++)
            for (int c = 0; c < corelet_pkg::cols; c++)
            begin
                sum = 0;
                for (int k = 0; k < corelet_pkg::kij_count; k++)
                begin
                    a_addr = 7'(corelet_pkg::act_base + window_offset[k] + p + 2 * (p / 4));
                    w_addr = 7'(k * 8 + c);
                    aw = mem[a_addr];
                    ww = mem[w_addr];
                    for (int l = 0; l < corelet_pkg::lanes; l++)
                        sum += int'(aw.act[l]) * int'(ww.weight[l]);
                end
                exp_row[p][c] = 16'(sum);
            end
    endtask

    task automatic run_conv(input bit poke, output bit timed_out);
        int cycles;
        int writes_before;
        timed_out = 1'b0;
        writes_before = write_count;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);     // start taken on this edge
        start <= 1'b0;
        cycles = 0;
        do
        begin
            @(posedge clk);
            cycles++;
            start <= (poke && cycles == 100);   // stray start while busy
        end
        while (!op_done && cycles < 400);
        if (!op_done)
        begin
            timed_out = 1'b1;
            timeouts++;
            $display("timeout: op_done never came after start");
        end
        else
        begin
            assert (cycles == corelet_pkg::kij_count * (corelet_pkg::cols +
                    corelet_pkg::positions) + corelet_pkg::flush_cycles +
                    corelet_pkg::positions + 1) else
            begin
                run_errors++;
                $display("FAIL op_done delay: got %h expected %h", cycles, 235);
            end
            assert (write_count - writes_before == 16) else
            begin
                run_errors++;
                $display("FAIL write_count: got %h expected %h", write_count - writes_before, 16);
            end
            for (int p = 0; p < corelet_pkg::positions; p++)
                assert (out_mem[p] == exp_row[p]) else
                begin
                    run_errors++;
                    $display("FAIL out_mem[%0d]: got %h expected %h", p, out_mem[p], exp_row[p]);
                end
        end
    endtask

    initial
    begin
        bit timed_out;
        reset = 1'b1;
        start = 1'b0;
        fill_input_sram();
        build_model();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        run_conv(1'b0, timed_out);
        if (!timed_out)
        begin
            fill_input_sram();  // fresh data, bank must not carry over
            build_model();
            run_conv(1'b1, timed_out);
        end
        $display("errors: write %0d, run %0d, timeout %0d", write_errors, run_errors, timeouts);
        if (write_errors == 0 && run_errors == 0 && timeouts == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
logic/corelet_pkg.sv
logic/conv_sequencer.sv
logic/mac_array.sv
logic/psum_accumulator.sv
logic/corelet_top.sv
bench/corelet_props.sv
bench/corelet_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f project.f --top-module corelet_tb -o corelet_sim

out=$(./obj_dir/corelet_sim 2>&1 || true)
printf '%s\n' "$out"

echo "$out" | grep -q "Test passed"
